// File: bench/sram_model.sv
/*
  Behavioral async SRAM for the bridge testbench
  16-bit device with byte lanes, or 8-bit device on the low lane
  Reads drive the data bus combinationally, writes store on rising WEn
*/
`timescale 1ns/1ps

module sram_model (
  input  logic              wide,      // 1 = 16-bit device
  input  extmem_pkg::addr_t addr,      // Byte address from the bridge
  input  extmem_pkg::half_t din,       // Bridge DATAOUT
  input  logic              cen,
  input  logic              oen,
  input  logic              wen,
  input  logic              lbn,
  input  logic              ubn,
  output extmem_pkg::half_t dout       // Bridge DATAIN
);

  import extmem_pkg::*;

  // Byte storage, same address space on both widths
  logic [7:0] mem [0:(1<<ADDR_W)-1];

  addr_t      lo_addr;
  addr_t      hi_addr;
  logic [7:0] lo_byte;
  logic [7:0] hi_byte;
  logic       rd_on;

  // ------------------------------------------------
  // Lane to byte mapping
  // ------------------------------------------------
  assign lo_addr = wide ? {addr[ADDR_W-1:1], 1'b0} : addr;   // 8-bit uses every address
  assign hi_addr = {addr[ADDR_W-1:1], 1'b1};

  assign rd_on   = (cen === 1'b0) && (oen === 1'b0);
  assign lo_byte = (rd_on && lbn === 1'b0) ? mem[lo_addr] : 8'hzz;
  assign hi_byte = (rd_on && ubn === 1'b0 && wide) ? mem[hi_addr] : 8'hzz;
  assign dout    = {hi_byte, lo_byte};   // Undriven lanes float

  // Store at the end of the write pulse
  always @(posedge wen)
  begin
    if (cen === 1'b0)
    begin
      if (lbn === 1'b0)
        mem[lo_addr] = din[7:0];
      if (ubn === 1'b0 && wide)
        mem[hi_addr] = din[15:8];        // No upper lane on an 8-bit part
    end
  end

endmodule

// File: bench/tb_ahb_to_extmem.sv
/*
  Testbench for the AHB to external memory bridge
  Random AHB transfers on 8 and 16 bit memories, checked against a byte-array reference
*/
`timescale 1ns/1ps

module tb_ahb_to_extmem;

  import extmem_pkg::*;

  typedef struct packed {
    logic       write;
    logic [2:0] size;
    addr_t      addr;
    word_t      wdata;
  } xfer_t;

  localparam int N_XFER  = 32 + 32 + 24 + 200;                   // Transfers over all tests
  localparam int TIMEOUT = N_XFER * 4 * (7 + 7 + 3) + 2000;      // Worst beat plus margin

  logic       HCLK;
  logic       HRESETn;
  logic       hsel;
  logic       hwrite;
  logic [1:0] htrans;
  logic [2:0] hsize;
  addr_t      haddr;
  word_t      hwdata;
  word_t      hrdata;
  logic       hreadyout;
  ext_cfg_t   cfg;
  addr_t      mem_addr;
  half_t      datain;
  half_t      dataout;
  logic       dataoen, wen, oen, cen, lbn, ubn;

  logic [7:0] ref_mem [0:(1<<ADDR_W)-1];   // Reference memory contents
  xfer_t      xq[$];                       // Pending transfers
  xfer_t      dp;                          // Transfer in data phase
  logic       dp_on;
  integer     seed;
  int         err_cnt, chk_cnt, test_err, cycle_cnt, wen_cyc;
  addr_t      prev_addr;
  logic       prev_wen, prev_lbn, prev_ubn;

  ahb_to_extmem UUT (
    .HCLK (HCLK), .HRESETn (HRESETn), .HSEL (hsel), .HADDR (haddr), .HTRANS (htrans),
    .HSIZE (hsize), .HWRITE (hwrite), .HWDATA (hwdata), .HREADY (hreadyout),
    .HREADYOUT (hreadyout), .HRDATA (hrdata), .cfg (cfg), .DATAIN (datain),
    .ADDR (mem_addr), .DATAOUT (dataout), .DATAOEn (dataoen), .WEn (wen), .OEn (oen),
    .CEn (cen), .LBn (lbn), .UBn (ubn)
  );

  sram_model u_sram (
    .wide (cfg.wide), .addr (mem_addr), .din (dataout), .cen (cen), .oen (oen),
    .wen (wen), .lbn (lbn), .ubn (ubn), .dout (datain)
  );

  // ------------------------------------------------
  // Clock and timeout
  // ------------------------------------------------
  initial
  begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;   // 4 ns period
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT)
    begin
      @(posedge HCLK);
      cycle_cnt++;
    end
    $display("Run timed out after %0d cycles, transfers did not complete", cycle_cnt);
    $display("RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------
  // Reference model and AHB driver
  // ------------------------------------------------
  function automatic xfer_t new_xfer(input logic write, input logic [2:0] size, input addr_t a);
    xfer_t x;
    x.write = write;
    x.size  = size;
    x.addr  = a;
    if (size == SIZE_HALF)
      x.addr[0] = 1'b0;
    if (size == SIZE_WORD)
      x.addr[1:0] = 2'b00;               // Aligned only
    x.wdata = $random(seed);             // Unused lanes random too
    return x;
  endfunction

  task automatic apply_write(input xfer_t x);
    int    k;
    addr_t a;
    for (k = 0; k < (1 << x.size); k++)
    begin
      a          = x.addr + addr_t'(k);
      ref_mem[a] = x.wdata[8*a[1:0] +: 8];   // Little endian lanes
    end
  endtask

  task automatic check_read(input xfer_t x);
    int         k;
    addr_t      a;
    logic [7:0] got;
    for (k = 0; k < (1 << x.size); k++)
    begin
      a   = x.addr + addr_t'(k);
      got = hrdata[8*a[1:0] +: 8];
      chk_cnt++;
      assert (got === ref_mem[a])
      else
      begin
        $display("[ERROR] %0t ns: read 0x%04h size %0d byte 0x%02h, expected 0x%02h",
                 $time, a, x.size, got, ref_mem[a]);
        err_cnt++;
      end
    end
  endtask

  task automatic drive_addr(input logic on, input xfer_t x);
    hsel   = on;
    htrans = on ? 2'b10 : 2'b00;         // NONSEQ or IDLE
    hwrite = x.write;
    hsize  = x.size;
    haddr  = x.addr;
  endtask

  // Pipelined issue, next address phase overlaps the current data phase
  task automatic run_queue;
    xfer_t ap;
    logic  ap_on;
    logic  rdy;
    ap    = '0;
    ap_on = 1'b0;
    while (xq.size() > 0 || ap_on || dp_on)
    begin
      @(negedge HCLK);
      rdy = hreadyout;                   // Value seen at the coming edge
      if (rdy && dp_on && !dp.write)
        check_read(dp);
      @(posedge HCLK);
      #1;
      if (rdy)
      begin
        dp    = ap;
        dp_on = ap_on;
        if (dp_on && dp.write)
        begin
          hwdata = dp.wdata;
          apply_write(dp);
        end
        ap_on = (xq.size() > 0);
        if (ap_on)
          ap = xq.pop_front();
        drive_addr(ap_on, ap);
      end
    end
  endtask

  task automatic set_cfg(input logic wide);
    repeat (8) @(posedge HCLK);          // Let a turnaround run out
    #1;
    cfg.read_cyc  = cyc_t'($random(seed));
    cfg.write_cyc = cyc_t'($random(seed));
    cfg.turn_cyc  = cyc_t'($random(seed));
    cfg.wide      = wide;
  endtask

  task automatic end_test(input string name);
    $display("Test %-36s %0d errors", name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  // ------------------------------------------------
  // Pin monitor
  // ------------------------------------------------
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      if (!wen && !prev_wen)
      begin
        wen_cyc++;
        chk_cnt++;
        assert (mem_addr === prev_addr && lbn === prev_lbn && ubn === prev_ubn)
        else
        begin
          $display("[ERROR] %0t ns: ADDR or lanes moved during WEn low", $time);
          err_cnt++;
        end
      end
      assert (wen || !dataoen)           // Data must be driven under WEn
      else
      begin
        $display("[ERROR] %0t ns: WEn low with DATAOEn high", $time);
        err_cnt++;
      end
      assert (!cfg.wide ? ubn !== 1'b0 : 1'b1)
      else
      begin
        $display("[ERROR] %0t ns: UBn low on 8-bit memory", $time);
        err_cnt++;
      end
      if (dp_on && cfg.wide && dp.size == SIZE_BYTE && cen === 1'b0)
      begin
        chk_cnt++;
        assert (lbn !== ubn && ubn === ~dp.addr[0])
        else
        begin
          $display("[ERROR] %0t ns: byte beat lanes LBn=%b UBn=%b for addr 0x%04h",
                   $time, lbn, ubn, dp.addr);
          err_cnt++;
        end
      end
    end
    prev_wen  = wen;
    prev_addr = mem_addr;
    prev_lbn  = lbn;
    prev_ubn  = ubn;
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial
  begin
    xfer_t x;
    xfer_t wq[$];
    int    i;
    int    g;
    addr_t w;
    seed     = 13;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_err = 0;
    wen_cyc  = 0;
    prev_wen = 1'b1;
    HRESETn  = 1'b0;
    hwdata   = '0;
    cfg      = '0;
    cfg.wide = 1'b1;
    dp       = '0;
    dp_on    = 1'b0;
    drive_addr(1'b0, dp);
    for (i = 0; i < (1 << ADDR_W); i++)
    begin
      ref_mem[i]    = i[7:0] ^ i[15:8] ^ 8'h5a;   // Fill tied to full address
      u_sram.mem[i] = ref_mem[i];
    end
    repeat (16) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    // 1: reset state, then unselected and idle transfers
    @(negedge HCLK);
    chk_cnt++;
    assert ({hreadyout, cen, oen, wen, lbn, ubn, dataoen} === 7'h7f)
    else
    begin
      $display("[ERROR] %0t ns: outputs not inactive after reset", $time);
      err_cnt++;
    end
    @(posedge HCLK);
    #1;
    htrans = 2'b10;                      // NONSEQ while unselected
    @(posedge HCLK);
    #1;
    hsel   = 1'b1;
    htrans = 2'b00;                      // Selected but idle
    repeat (4)
    begin
      @(negedge HCLK);
      chk_cnt++;
      assert (hreadyout === 1'b1 && cen === 1'b1)
      else
      begin
        $display("[ERROR] %0t ns: idle or unselected transfer started an access", $time);
        err_cnt++;
      end
    end
    end_test("1 reset and idle");

    // 2: 16-bit words and halfwords
    set_cfg(1'b1);
    for (i = 0; i < 16; i++)
    begin
      x = new_xfer(1'b1, i[0] ? SIZE_HALF : SIZE_WORD, addr_t'($random(seed)));
      wq.push_back(x);
      xq.push_back(x);
    end
    foreach (wq[j])
    begin
      x       = wq[j];
      x.write = 1'b0;
      xq.push_back(x);
    end
    run_queue();
    end_test("2 16-bit word and halfword");

    // 3: 16-bit byte lanes, even and odd byte into a known word
    set_cfg(1'b1);
    for (i = 0; i < 8; i++)
    begin
      w = addr_t'($random(seed));
      xq.push_back(new_xfer(1'b1, SIZE_WORD, w));
      xq.push_back(new_xfer(1'b1, SIZE_BYTE, {w[ADDR_W-1:2], 1'($random(seed)), 1'b0}));
      xq.push_back(new_xfer(1'b1, SIZE_BYTE, {w[ADDR_W-1:2], 1'($random(seed)), 1'b1}));
      xq.push_back(new_xfer(1'b0, SIZE_WORD, w));
    end
    run_queue();
    end_test("3 16-bit byte lanes");

    // 4: 8-bit memory, all sizes
    set_cfg(1'b0);
    wq.delete();
    for (i = 0; i < 12; i++)
    begin
      x = new_xfer(1'b1, 3'(i % 3), addr_t'($random(seed)));
      wq.push_back(x);
      xq.push_back(x);
    end
    foreach (wq[j])
    begin
      x       = wq[j];
      x.write = 1'b0;
      xq.push_back(x);
    end
    run_queue();
    end_test("4 8-bit memory");

    // 5: random mix, new timing and width per group
    for (g = 0; g < 10; g++)
    begin
      set_cfg(1'($random(seed)));
      for (i = 0; i < 20; i++)
        xq.push_back(new_xfer(1'($random(seed)), 3'(($random(seed) & 'hff) % 3),
                              addr_t'($random(seed))));
      run_queue();
    end
    end_test("5 random mix");

    // 6: write stability comes from the monitor
    if (wen_cyc == 0)
    begin
      $display("No write pulse was seen, write stability was never exercised");
      err_cnt++;
    end
    end_test($sformatf("6 write stability (%0d WEn cycles)", wen_cyc));

    $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: source/ahb_extmem_bus_fsm.sv
/*
  AHB side of the external memory bridge
  Captures each transfer, splits it into 8 or 16 bit memory beats,
  steers write bytes onto lanes and packs read bytes into HRDATA
*/
`timescale 1ns/1ps

module ahb_extmem_bus_fsm (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  // AHB slave side
  input  logic                  hsel,
  input  logic [1:0]            htrans,
  input  logic [2:0]            hsize,
  input  logic                  hwrite,
  input  logic                  hready,
  input  extmem_pkg::addr_t     haddr,
  input  extmem_pkg::word_t     hwdata,
  output logic                  hreadyout,
  output extmem_pkg::word_t     hrdata,
  // Memory width select
  input  logic                  wide,
  // Beat channel to timing FSM
  output extmem_pkg::mem_beat_t beat,
  output logic                  beat_valid,
  input  logic                  beat_ready,
  input  extmem_pkg::half_t     beat_rdata
);

  import extmem_pkg::*;

  bus_state_t state;

  // Registered address phase
  addr_t      addr_q;
  logic [2:0] size_q;
  logic       write_q;
  word_t      wdata_q;     // HWDATA held for later beats

  logic [1:0] idx;         // Current beat
  logic [1:0] last_idx;    // Beat count minus one
  logic [1:0] beats_m1;    // From live HSIZE

  logic       accept;
  logic       start;
  logic       beat_done;
  logic       last_beat;

  word_t      wword;       // Write word feeding the lanes
  logic [7:0] wbyte;       // Single byte for 8-bit memory
  addr_t      beat_addr;
  lane_t      beat_lanes;
  half_t      beat_wdata;

  // ------------------------------------------------
  // Address phase decode
  // ------------------------------------------------
  assign accept    = hsel & htrans[HTRANS_NONSEQ_BIT] & hready;
  assign start     = accept & hreadyout;   // Only in IDLE or DONE
  assign beat_done = beat_valid & beat_ready;
  assign last_beat = (idx == last_idx);

  // Beats per transfer
  always_comb
  begin
    case (hsize)
      SIZE_BYTE: beats_m1 = 2'd0;
      SIZE_HALF: beats_m1 = wide ? 2'd0 : 2'd1;
      SIZE_WORD: beats_m1 = wide ? 2'd1 : 2'd3;
      default:   beats_m1 = 2'd0;   // Larger sizes not supported
    endcase
  end

  // ------------------------------------------------
  // Control FSM
  // ------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state      <= BUS_IDLE;
      hreadyout  <= 1'b1;
      beat_valid <= 1'b0;
      idx        <= 2'd0;
      last_idx   <= 2'd0;
      size_q     <= SIZE_BYTE;
      write_q    <= 1'b0;
    end
    else
    begin
      case (state)
        BUS_IDLE, BUS_DONE:
        begin
          if (start)
          begin
            state      <= BUS_ISSUE;
            hreadyout  <= 1'b0;         // Stretch the data phase
            beat_valid <= 1'b1;         // First beat right away
            idx        <= 2'd0;
            last_idx   <= beats_m1;
            size_q     <= hsize;
            write_q    <= hwrite;
          end
          else
          begin
            state <= BUS_IDLE;
          end
        end

        BUS_ISSUE, BUS_WAIT:
        begin
          state <= BUS_WAIT;
          if (beat_done)
          begin
            if (last_beat)
            begin
              state      <= BUS_DONE;
              hreadyout  <= 1'b1;       // One cycle, data valid
              beat_valid <= 1'b0;
            end
            else
            begin
              idx <= idx + 2'd1;        // Next beat on the next cycle
            end
          end
        end

        default:
        begin
          state <= BUS_IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------
  // Payload registers
  // ------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (start)
      addr_q <= haddr;
    if (state == BUS_ISSUE)
      wdata_q <= hwdata;                // HWDATA valid in first data cycle
    if (beat_done && !write_q)
    begin
      if (wide)
      begin
        if (beat_lanes[0])
          hrdata[16*beat_addr[1] +: 8] <= beat_rdata[7:0];
        if (beat_lanes[1])
          hrdata[16*beat_addr[1] + 8 +: 8] <= beat_rdata[15:8];
      end
      else
      begin
        hrdata[8*beat_addr[1:0] +: 8] <= beat_rdata[7:0];  // Low lane only
      end
    end
  end

  // ------------------------------------------------
  // Beat formation
  // ------------------------------------------------
  // Live HWDATA in the issue cycle, held copy after that
  assign wword = (state == BUS_ISSUE) ? hwdata : wdata_q;

  // Low address bits replaced by the beat index
  always_comb
  begin
    beat_addr = addr_q;
    if (wide)
    begin
      if (size_q == SIZE_WORD)
        beat_addr[1] = idx[0];          // Two halfwords
    end
    else
    begin
      if (size_q == SIZE_HALF)
        beat_addr[0] = idx[0];          // Two bytes
      else if (size_q == SIZE_WORD)
        beat_addr[1:0] = idx;           // Four bytes
    end
  end

  // Lane select
  always_comb
  begin
    if (!wide)
      beat_lanes = 2'b01;               // 8-bit device on the low lane
    else if (size_q == SIZE_BYTE)
      beat_lanes = beat_addr[0] ? 2'b10 : 2'b01;
    else
      beat_lanes = 2'b11;
  end

  // Write data steering
  assign wbyte = wword[8*beat_addr[1:0] +: 8];

  always_comb
  begin
    if (wide)
      beat_wdata = wword[16*beat_addr[1] +: 16];  // Bytes already on their lanes
    else
      beat_wdata = {wbyte, wbyte};
  end

  always_comb
  begin
    beat.addr  = beat_addr;
    beat.wdata = beat_wdata;
    beat.lanes = beat_lanes;
    beat.write = write_q;
  end

endmodule

// File: source/ahb_to_extmem.sv
/*
  AHB to external async SRAM/PSRAM bridge, 8 or 16 bit devices
  Bus FSM splits transfers into beats, timing FSM runs the pins
*/
`timescale 1ns/1ps

module ahb_to_extmem (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // AHB slave
  input  logic                 HSEL,
  input  extmem_pkg::addr_t    HADDR,
  input  logic [1:0]           HTRANS,
  input  logic [2:0]           HSIZE,
  input  logic                 HWRITE,
  input  extmem_pkg::word_t    HWDATA,
  input  logic                 HREADY,
  output logic                 HREADYOUT,
  output extmem_pkg::word_t    HRDATA,
  // Static setup
  input  extmem_pkg::ext_cfg_t cfg,
  // Memory pins
  input  extmem_pkg::half_t    DATAIN,
  output extmem_pkg::addr_t    ADDR,
  output extmem_pkg::half_t    DATAOUT,
  output logic                 DATAOEn,   // Pad driver enable
  output logic                 WEn,
  output logic                 OEn,
  output logic                 CEn,
  output logic                 LBn,
  output logic                 UBn
);

  import extmem_pkg::*;

  // ------------------------------------------------
  // Beat channel
  // ------------------------------------------------
  mem_beat_t beat;
  logic      beat_valid;
  logic      beat_ready;     // One cycle pulse per beat
  half_t     beat_rdata;

  // Transfer split and data routing
  ahb_extmem_bus_fsm u_bus (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hsel       (HSEL),
    .htrans     (HTRANS),
    .hsize      (HSIZE),
    .hwrite     (HWRITE),
    .hready     (HREADY),
    .haddr      (HADDR),
    .hwdata     (HWDATA),
    .hreadyout  (HREADYOUT),
    .hrdata     (HRDATA),
    .wide       (cfg.wide),    // Only the width reaches the bus side
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat_rdata (beat_rdata)
  );

  // Pin timing per beat
  extmem_timing_fsm u_mem (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .cfg        (cfg),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat_rdata (beat_rdata),
    .datain     (DATAIN),
    .addr       (ADDR),
    .dataout    (DATAOUT),
    .dataoen    (DATAOEn),
    .wen        (WEn),
    .oen        (OEn),
    .cen        (CEn),
    .lbn        (LBn),
    .ubn        (UBn)
  );

endmodule

// File: source/extmem_pkg.sv
/*
  External memory bridge shared definitions
  Widths, bus encodings, beat and config structs, FSM state types
*/
package extmem_pkg;

  // ------------------------------------------------
  // Widths and AHB encodings
  // ------------------------------------------------
  localparam int ADDR_W = 16;             // 64 KB memory window

  localparam int HTRANS_NONSEQ_BIT = 1;   // Set for NONSEQ and SEQ

  localparam logic [2:0] SIZE_BYTE = 3'b000;
  localparam logic [2:0] SIZE_HALF = 3'b001;
  localparam logic [2:0] SIZE_WORD = 3'b010;

  // ------------------------------------------------
  // Vector types
  // ------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;      // Byte address
  typedef logic [31:0]       word_t;      // AHB data word
  typedef logic [15:0]       half_t;      // Memory data bus
  typedef logic [2:0]        cyc_t;       // Wait cycle count
  typedef logic [1:0]        lane_t;      // Byte lanes, active high

  // Static timing and width setup
  typedef struct packed {
    cyc_t read_cyc;    // Extra read cycles
    cyc_t write_cyc;   // Extra WEn pulse cycles
    cyc_t turn_cyc;    // Idle cycles after a read
    logic wide;        // 1 = 16-bit memory
  } ext_cfg_t;

  // One access on the memory pins
  typedef struct packed {
    addr_t addr;
    half_t wdata;      // Already steered onto lanes
    lane_t lanes;
    logic  write;
  } mem_beat_t;

  // ------------------------------------------------
  // State machines
  // ------------------------------------------------
  typedef enum logic [1:0] {
    BUS_IDLE,          // No transfer in data phase
    BUS_ISSUE,         // First data phase cycle
    BUS_WAIT,          // Beats in flight
    BUS_DONE           // HREADYOUT high, data returned
  } bus_state_t;

  typedef enum logic [2:0] {
    MEM_IDLE,
    MEM_READ,          // CEn and OEn low
    MEM_WR_SETUP,      // Address and data out before WEn
    MEM_WR_PULSE,      // WEn low
    MEM_WR_HOLD,       // WEn high again, data still driven
    MEM_TURN           // Bus turnaround after a read
  } mem_state_t;

endpackage

// File: source/extmem_timing_fsm.sv
/*
  Memory side of the external memory bridge
  Times each beat on an async SRAM/PSRAM and drives registered strobes
*/
`timescale 1ns/1ps

module extmem_timing_fsm (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  extmem_pkg::ext_cfg_t  cfg,
  // Beat channel from bus FSM
  input  extmem_pkg::mem_beat_t beat,
  input  logic                  beat_valid,
  output logic                  beat_ready,
  output extmem_pkg::half_t     beat_rdata,
  // Memory pins
  input  extmem_pkg::half_t     datain,
  output extmem_pkg::addr_t     addr,
  output extmem_pkg::half_t     dataout,
  output logic                  dataoen,
  output logic                  wen,
  output logic                  oen,
  output logic                  cen,
  output logic                  lbn,
  output logic                  ubn
);

  import extmem_pkg::*;

  mem_state_t state;
  mem_state_t state_nxt;
  cyc_t       cnt;          // Shared down-counter
  cyc_t       cnt_nxt;

  lane_t      lanes_q;      // Lanes of the beat in progress
  lane_t      lane_nxt;
  logic       start;
  logic       access_nxt;   // Chip selected next cycle

  assign start = (state == MEM_IDLE) & beat_valid;

  // ------------------------------------------------
  // Next state and counter
  // ------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    cnt_nxt   = cnt;
    case (state)
      MEM_IDLE:
      begin
        if (start)
        begin
          if (beat.write)
          begin
            state_nxt = MEM_WR_SETUP;
          end
          else
          begin
            state_nxt = MEM_READ;
            cnt_nxt   = cfg.read_cyc;
          end
        end
      end

      MEM_READ:
      begin
        if (cnt == '0)
        begin
          state_nxt = (cfg.turn_cyc != '0) ? MEM_TURN : MEM_IDLE;
          cnt_nxt   = cfg.turn_cyc - cyc_t'(1);
        end
        else
        begin
          cnt_nxt = cnt - cyc_t'(1);
        end
      end

      MEM_WR_SETUP:
      begin
        state_nxt = MEM_WR_PULSE;
        cnt_nxt   = cfg.write_cyc;
      end

      MEM_WR_PULSE:
      begin
        if (cnt == '0)
          state_nxt = MEM_WR_HOLD;
        else
          cnt_nxt = cnt - cyc_t'(1);
      end

      MEM_WR_HOLD: state_nxt = MEM_IDLE;      // No turnaround on writes

      MEM_TURN:
      begin
        if (cnt == '0)
          state_nxt = MEM_IDLE;
        else
          cnt_nxt = cnt - cyc_t'(1);
      end

      default: state_nxt = MEM_IDLE;
    endcase
  end

  assign access_nxt = (state_nxt != MEM_IDLE) && (state_nxt != MEM_TURN);
  assign lane_nxt   = start ? beat.lanes : lanes_q;

  // ------------------------------------------------
  // State and strobe registers
  // ------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state   <= MEM_IDLE;
      cnt     <= '0;
      cen     <= 1'b1;
      oen     <= 1'b1;
      wen     <= 1'b1;
      dataoen <= 1'b1;
      lbn     <= 1'b1;
      ubn     <= 1'b1;
    end
    else
    begin
      state   <= state_nxt;
      cnt     <= cnt_nxt;
      cen     <= ~access_nxt;
      oen     <= ~(state_nxt == MEM_READ);
      wen     <= ~(state_nxt == MEM_WR_PULSE);
      dataoen <= ~(state_nxt inside {MEM_WR_SETUP, MEM_WR_PULSE, MEM_WR_HOLD});
      lbn     <= ~(access_nxt & lane_nxt[0]);
      ubn     <= ~(access_nxt & lane_nxt[1]);
    end
  end

  // Address, data and lanes fixed for the whole beat
  always_ff @(posedge HCLK)
  begin
    if (start)
    begin
      addr    <= beat.addr;
      dataout <= beat.wdata;
      lanes_q <= beat.lanes;
    end
  end

  // ------------------------------------------------
  // Beat completion
  // ------------------------------------------------
  // Last read cycle or write hold cycle
  assign beat_ready = ((state == MEM_READ) && (cnt == '0)) || (state == MEM_WR_HOLD);

  // Unused lane forced to zero, bus side samples on ready
  assign beat_rdata = {lanes_q[1] ? datain[15:8] : 8'h00,
                       lanes_q[0] ? datain[7:0]  : 8'h00};

endmodule

// File: src.f
source/extmem_pkg.sv
source/ahb_extmem_bus_fsm.sv
source/extmem_timing_fsm.sv
source/ahb_to_extmem.sv
bench/sram_model.sv
bench/tb_ahb_to_extmem.sv
